//--- fetch_defs.svh
// macros for pc and instruction widths, fetch width, table sizes and stack depth.
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

////////////////////////////////////////////////////////////
// datapath widths.
// program counter width in bits.
`define SIZE_PC 32
// instructions fetched per cycle.
`define FETCH_WIDTH 4
// width of one instruction word.
`define INST_WIDTH 32

////////////////////////////////////////////////////////////
// table and stack sizes.
// branch target buffer entries, direct mapped.
`define BTB_ENTRIES 16
// bimodal counter table entries.
`define BPB_ENTRIES 64
// return address stack depth.
`define RAS_DEPTH 8
// instruction cache lines, one bundle each.
`define ICACHE_LINES 16

`endif

//--- fetchPkg.sv
// fetch types: control-type enum, bundle, update, prediction, redirect and fill structs.
`include "fetch_defs.svh"

package fetchPkg;

  // control instruction classes, in the encoding the btb stores.
  typedef enum logic [1:0] {
    RETURN = 2'b00,
    CALL   = 2'b01,
    JUMP   = 2'b10,
    COND   = 2'b11
  } ctrlType_e;

  // four instruction words, slot 0 in the low bits.
  typedef logic [`FETCH_WIDTH-1:0][`INST_WIDTH-1:0] bundle_t;

  // one resolved control instruction, arriving in program order.
  typedef struct packed {
    logic                en;
    logic [`SIZE_PC-1:0] pc;
    logic [`SIZE_PC-1:0] target;
    ctrlType_e           brType;
    logic                taken;
  } btbUpdate_t;

  // per-slot prediction seen by decode.
  typedef struct packed {
    logic                btbHit;
    logic                prediction;
    logic [`SIZE_PC-1:0] target;
  } slotPred_t;

  // recovery, exception and execute redirect.
  typedef struct packed {
    logic                valid;
    logic [`SIZE_PC-1:0] target;
  } redirect_t;

  // decode redirect; carries call/return info the btb missed.
  typedef struct packed {
    logic                valid;
    logic                isCall;
    logic                isReturn;
    logic [`SIZE_PC-1:0] callPc;
    logic [`SIZE_PC-1:0] target;
  } idRedirect_t;

  // line fill from lower memory.
  typedef struct packed {
    logic                en;
    logic [`SIZE_PC-1:0] addr;
    bundle_t             block;
  } fill_t;

endpackage

//--- btb.sv
// direct-mapped branch target buffer with four lookup ports and one update port.
`include "fetch_defs.svh"

module btb
  import fetchPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`SIZE_PC-1:0]     lookupPc_i,
  input  logic                    updEn_i,
  input  btbUpdate_t              upd_i,
  output logic [`FETCH_WIDTH-1:0] hit_o,
  output ctrlType_e               ctrlType_o [`FETCH_WIDTH],
  output logic [`SIZE_PC-1:0]     target_o [`FETCH_WIDTH]
);

  localparam int IdxW = $clog2(`BTB_ENTRIES);
  localparam int TagW = `SIZE_PC - IdxW - 2;
  localparam int PcW  = `SIZE_PC;

  // stored payload of one entry.
  typedef struct packed {
    logic [TagW-1:0]     tag;
    ctrlType_e           brType;
    logic [`SIZE_PC-1:0] target;
  } btbEntry_t;

  logic [`BTB_ENTRIES-1:0] valid;
  btbEntry_t               entries [`BTB_ENTRIES];
  logic [IdxW-1:0]         updIdx;

  // index from word address bits.
  assign updIdx = upd_i.pc[IdxW+1:2];

  // valid bits are the only control state.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (updEn_i) begin
      valid[updIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (updEn_i) begin
      entries[updIdx] <= '{tag: upd_i.pc[`SIZE_PC-1:IdxW+2],
                           brType: upd_i.brType,
                           target: upd_i.target};
    end
  end

  ////////////////////////////////////////////////////////////
  // lookup, one port per slot of the bundle.
  always_comb begin : lookup
    logic [`SIZE_PC-1:0] slotPc;
    logic [IdxW-1:0]     idx;
    slotPc = '0;
    idx    = '0;
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      // slot s sits 4*s bytes past the bundle base.
      slotPc        = lookupPc_i + PcW'(4 * s);
      idx           = slotPc[IdxW+1:2];
      hit_o[s]      = valid[idx] && (entries[idx].tag == slotPc[`SIZE_PC-1:IdxW+2]);
      ctrlType_o[s] = entries[idx].brType;
      target_o[s]   = entries[idx].target;
    end
  end

  // slot addresses only make sense from a word-aligned base.
  assert property (@(posedge clk) disable iff (reset) lookupPc_i[1:0] == 2'b00)
    else $error("btb: unaligned lookup pc %h", lookupPc_i);

endmodule

//--- branchPredictor.sv
// bimodal direction predictor of 2-bit counters, four lookup ports and one update port.
`include "fetch_defs.svh"

module branchPredictor (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`SIZE_PC-1:0]     lookupPc_i,
  input  logic                    updEn_i,
  input  logic [`SIZE_PC-1:0]     updPc_i,
  input  logic                    updTaken_i,
  output logic [`FETCH_WIDTH-1:0] prediction_o
);

  localparam int IdxW = $clog2(`BPB_ENTRIES);
  localparam int PcW  = `SIZE_PC;

  logic [1:0]      counters [`BPB_ENTRIES];
  logic [IdxW-1:0] updIdx;

  assign updIdx = updPc_i[IdxW+1:2];

  // counters start weakly not-taken.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `BPB_ENTRIES; i++) begin
        counters[i] <= 2'b01;
      end
    end else if (updEn_i) begin
      // saturate at 11 and 00.
      if (updTaken_i && counters[updIdx] != 2'b11) begin
        counters[updIdx] <= counters[updIdx] + 2'b01;
      end else if (!updTaken_i && counters[updIdx] != 2'b00) begin
        counters[updIdx] <= counters[updIdx] - 2'b01;
      end
    end
  end

  // taken when the counter msb is set.
  always_comb begin : lookup
    logic [`SIZE_PC-1:0] slotPc;
    slotPc = '0;
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      slotPc          = lookupPc_i + PcW'(4 * s);
      prediction_o[s] = counters[slotPc[IdxW+1:2]][1];
    end
  end

endmodule

//--- returnAddrStack.sv
// circular return address stack with push, pop and top-of-stack read.
`include "fetch_defs.svh"

module returnAddrStack (
  input  logic                clk,
  input  logic                reset,
  input  logic                push_i,
  input  logic [`SIZE_PC-1:0] pushAddr_i,
  input  logic                pop_i,
  output logic [`SIZE_PC-1:0] top_o
);

  localparam int PtrW = $clog2(`RAS_DEPTH);
  localparam int CntW = $clog2(`RAS_DEPTH + 1);
  localparam logic [CntW-1:0] Full = CntW'(`RAS_DEPTH);

  logic [`SIZE_PC-1:0] stack [`RAS_DEPTH];
  logic [PtrW-1:0]     ptr;
  // live entries since reset, saturating at the depth.
  logic [CntW-1:0]     depth;

  ////////////////////////////////////////////////////////////
  // pointer and occupancy.
  always_ff @(posedge clk) begin
    if (reset) begin
      ptr   <= '0;
      depth <= '0;
    end else if (push_i && !pop_i) begin
      // pointer wraps; the oldest entry is lost on overflow.
      ptr   <= ptr + 1'b1;
      depth <= (depth == Full) ? depth : depth + 1'b1;
    end else if (pop_i && !push_i) begin
      ptr   <= ptr - 1'b1;
      depth <= (depth == '0) ? depth : depth - 1'b1;
    end
  end

  // push and pop together replace the top.
  always_ff @(posedge clk) begin
    if (push_i && pop_i) begin
      stack[ptr] <= pushAddr_i;
    end else if (push_i) begin
      stack[ptr + 1'b1] <= pushAddr_i;
    end
  end

  assign top_o = stack[ptr];

  // a lone pop needs a push somewhere earlier since reset.
  assert property (@(posedge clk) disable iff (reset) (pop_i && !push_i) |-> depth != '0)
    else $error("ras: pop from empty stack");

endmodule

//--- instCache.sv
// direct-mapped instruction cache of bundle lines with miss detection and line fill.
`include "fetch_defs.svh"

module instCache
  import fetchPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [`SIZE_PC-1:0] addr_i,
  input  fill_t               fill_i,
  output bundle_t             bundle_o,
  output logic                miss_o,
  output logic [`SIZE_PC-1:0] missAddr_o
);

  localparam int IdxW = $clog2(`ICACHE_LINES);
  // byte offset inside one bundle.
  localparam int OffW = $clog2(`FETCH_WIDTH * `INST_WIDTH / 8);
  localparam int TagW = `SIZE_PC - IdxW - OffW;

  // tag and data of one line.
  typedef struct packed {
    logic [TagW-1:0] tag;
    bundle_t         data;
  } line_t;

  logic [`ICACHE_LINES-1:0] valid;
  line_t                    lines [`ICACHE_LINES];
  logic [IdxW-1:0]          rdIdx;
  logic [IdxW-1:0]          fillIdx;
  logic [TagW-1:0]          rdTag;

  assign rdIdx   = addr_i[OffW +: IdxW];
  assign rdTag   = addr_i[`SIZE_PC-1 -: TagW];
  assign fillIdx = fill_i.addr[OffW +: IdxW];

  ////////////////////////////////////////////////////////////
  // fill path.
  // all lines invalid after reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (fill_i.en) begin
      valid[fillIdx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i.en) begin
      lines[fillIdx] <= '{tag: fill_i.addr[`SIZE_PC-1 -: TagW], data: fill_i.block};
    end
  end

  ////////////////////////////////////////////////////////////
  // read path, combinational.
  assign bundle_o = lines[rdIdx].data;

  // miss on an empty line or a tag mismatch.
  assign miss_o = !valid[rdIdx] || (lines[rdIdx].tag != rdTag);

  // request goes out bundle-aligned.
  assign missAddr_o = {addr_i[`SIZE_PC-1:OffW], {OffW{1'b0}}};

endmodule

//--- fetchStage1.sv
// fetch stage 1: pc register, slot qualifier, ras control, next-pc encoder and outputs.
`include "fetch_defs.svh"

module fetchStage1
  import fetchPkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  redirect_t           recover_i,
  input  redirect_t           exception_i,
  input  redirect_t           redirectEx_i,
  input  idRedirect_t         redirectId_i,
  input  btbUpdate_t          update_i,
  input  fill_t               fill_i,
  input  logic                stall_i,
  output logic [`SIZE_PC-1:0] pc_o,
  output bundle_t             bundle_o,
  output logic                fs1Ready_o,
  output slotPred_t           slotPred_o [`FETCH_WIDTH],
  output logic                miss_o,
  output logic [`SIZE_PC-1:0] missAddr_o
);

  localparam int PcW         = `SIZE_PC;
  localparam int SlotW       = $clog2(`FETCH_WIDTH);
  localparam int BundleBytes = `FETCH_WIDTH * `INST_WIDTH / 8;
  localparam int OffW        = $clog2(BundleBytes);

  logic [`SIZE_PC-1:0]     pc;
  logic [`SIZE_PC-1:0]     nextPc;
  logic                    loadPc;
  // unit results.
  logic [`FETCH_WIDTH-1:0] btbHit;
  ctrlType_e               btbType [`FETCH_WIDTH];
  logic [`SIZE_PC-1:0]     btbTarget [`FETCH_WIDTH];
  logic [`FETCH_WIDTH-1:0] prediction;
  logic [`SIZE_PC-1:0]     rasTop;
  logic                    miss;
  logic                    btbUpdEn;
  logic                    bpUpdEn;
  // slot qualifier results.
  logic [`FETCH_WIDTH-1:0] slotTaken;
  logic [`SIZE_PC-1:0]     slotTarget [`FETCH_WIDTH];
  logic                    predTaken;
  logic [SlotW-1:0]        predSlot;
  // ras control.
  logic                    lateRedirect;
  logic                    advance;
  logic                    rasPush;
  logic                    rasPop;
  logic [`SIZE_PC-1:0]     rasPushAddr;

  // btb learns only taken conditionals; the predictor learns only conditionals.
  assign btbUpdEn = update_i.en && (update_i.brType != COND || update_i.taken);
  assign bpUpdEn  = update_i.en && (update_i.brType == COND);

  btb u_btb (.clk, .reset, .lookupPc_i(pc), .updEn_i(btbUpdEn), .upd_i(update_i),
             .hit_o(btbHit), .ctrlType_o(btbType), .target_o(btbTarget));

  branchPredictor u_bp (.clk, .reset, .lookupPc_i(pc), .updEn_i(bpUpdEn),
                        .updPc_i(update_i.pc), .updTaken_i(update_i.taken),
                        .prediction_o(prediction));

  returnAddrStack u_ras (.clk, .reset, .push_i(rasPush), .pushAddr_i(rasPushAddr),
                         .pop_i(rasPop), .top_o(rasTop));

  instCache u_icache (.clk, .reset, .addr_i(pc), .fill_i, .bundle_o, .miss_o(miss),
                      .missAddr_o);

  ////////////////////////////////////////////////////////////
  // slot qualifier.
  always_comb begin : slotQualifier
    predTaken = 1'b0;
    predSlot  = '0;
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      // unconditional hits always redirect.
      slotTaken[s]  = btbHit[s] && (btbType[s] != COND || prediction[s]);
      slotTarget[s] = (btbType[s] == RETURN) ? rasTop : btbTarget[s];
    end
    // walk down so the lowest taken slot is left.
    for (int s = `FETCH_WIDTH - 1; s >= 0; s--) begin
      if (slotTaken[s]) begin
        predTaken = 1'b1;
        predSlot  = SlotW'(s);
      end
    end
  end

  // recovery, exception and execute override a stall or a miss.
  assign lateRedirect = recover_i.valid || exception_i.valid || redirectEx_i.valid;
  assign advance      = !stall_i && !miss;
  assign loadPc       = lateRedirect || advance;

  // ras selection; the decode redirect outranks the bundle.
  always_comb begin : rasSelect
    rasPush     = 1'b0;
    rasPop      = 1'b0;
    rasPushAddr = redirectId_i.callPc + PcW'(4);
    if (advance && !lateRedirect) begin
      if (redirectId_i.valid) begin
        rasPush = redirectId_i.isCall;
        rasPop  = redirectId_i.isReturn;
      end else if (predTaken) begin
        rasPush     = (btbType[predSlot] == CALL);
        rasPop      = (btbType[predSlot] == RETURN);
        // return point is the slot after the call.
        rasPushAddr = pc + PcW'(4 * (int'(predSlot) + 1));
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // next-pc priority encoder.
  always_comb begin : nextPcEncoder
    if (recover_i.valid) begin
      nextPc = recover_i.target;
    end else if (exception_i.valid) begin
      nextPc = exception_i.target;
    end else if (redirectEx_i.valid) begin
      nextPc = redirectEx_i.target;
    end else if (redirectId_i.valid) begin
      nextPc = redirectId_i.isReturn ? rasTop : redirectId_i.target;
    end else if (predTaken) begin
      nextPc = slotTarget[predSlot];
    end else begin
      nextPc = pc + PcW'(BundleBytes);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (loadPc) begin
      pc <= nextPc;
    end
  end

  // output drive.
  assign pc_o       = pc;
  assign miss_o     = miss;
  assign fs1Ready_o = !miss;

  always_comb begin : outputDrive
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      slotPred_o[s] = '{btbHit: btbHit[s], prediction: prediction[s], target: slotTarget[s]};
    end
  end

  // every source must hand back a bundle-aligned address.
  assert property (@(posedge clk) disable iff (reset) pc[OffW-1:0] == '0)
    else $error("fetch: pc %h not bundle aligned", pc);

endmodule

//--- tb_fetchStage1.sv
// testbench for fetchStage1: clock, reset, lcg, reference model, compare tasks, tests, watchdog.
`include "fetch_defs.svh"

module tb_fetchStage1
  import fetchPkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TotalCycles = 600;

  logic clk, reset, stall_i, miss_o, fs1Ready_o, autoFill;
  redirect_t recover_i, exception_i, redirectEx_i;
  idRedirect_t redirectId_i;
  btbUpdate_t update_i;
  fill_t fill_i;
  bundle_t bundle_o;
  slotPred_t slotPred_o [`FETCH_WIDTH];
  logic [`SIZE_PC-1:0] pc_o, missAddr_o, rng, expPc;
  // reference model state.
  logic [`SIZE_PC-1:0] btbPc [int];
  logic [`SIZE_PC-1:0] btbTgt [int];
  ctrlType_e btbTyp [int];
  logic [1:0] ctr [`BPB_ENTRIES];
  logic [`SIZE_PC-1:0] rasQ [$];
  logic [`SIZE_PC-1:0] filled [int];

  fetchStage1 u_fetchStage1 (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg(input logic [31:0] x);
    return x * 32'd1103515245 + 32'd12345;
  endfunction

  // lower memory contents, a hash of every address bit.
  function automatic bundle_t blockFor(input logic [`SIZE_PC-1:0] addr);
    bundle_t b;
    for (int s = 0; s < `FETCH_WIDTH; s++) b[s] = lcg(lcg(addr + 32'(4 * s)));
    return b;
  endfunction

  function automatic logic [`SIZE_PC-1:0] rasTop();
    return (rasQ.size() > 0) ? rasQ[$] : 'x;
  endfunction

  // hit and direction of one slot from the model tables.
  function automatic slotPred_t expectSlot(input logic [`SIZE_PC-1:0] pc, input int s);
    slotPred_t r;
    logic [`SIZE_PC-1:0] sp;
    int idx;
    sp = pc + 32'(4 * s);
    idx = sp[5:2];
    r.btbHit = btbPc.exists(idx) && btbPc[idx] == sp;
    r.prediction = ctr[sp[7:2]][1];
    r.target = 'x;
    if (r.btbHit) r.target = (btbTyp[idx] == RETURN) ? rasTop() : btbTgt[idx];
    return r;
  endfunction

  function automatic logic [`SIZE_PC-1:0] expectNextPc(input logic [`SIZE_PC-1:0] cur,
      input logic hold, output logic push, output logic pop,
      output logic [`SIZE_PC-1:0] pushAddr);
    logic [`SIZE_PC-1:0] nxt;
    logic late, found;
    int fs;
    slotPred_t sp;
    push = 0;
    pop = 0;
    pushAddr = 0;
    found = 0;
    fs = 0;
    nxt = cur + 32'd16;
    // lowest slot whose hit qualifies as taken.
    for (int s = `FETCH_WIDTH - 1; s >= 0; s--) begin
      sp = expectSlot(cur, s);
      if (sp.btbHit && (btbTyp[int'((cur + 32'(4 * s)) >> 2) % 16] != COND || sp.prediction)) begin
        found = 1;
        fs = s;
      end
    end
    if (found) nxt = expectSlot(cur, fs).target;
    if (redirectId_i.valid) nxt = redirectId_i.isReturn ? rasTop() : redirectId_i.target;
    late = recover_i.valid || exception_i.valid || redirectEx_i.valid;
    if (redirectEx_i.valid) nxt = redirectEx_i.target;
    if (exception_i.valid) nxt = exception_i.target;
    if (recover_i.valid) nxt = recover_i.target;
    if (!late && hold) nxt = cur;
    if (!late && !hold) begin
      if (redirectId_i.valid) begin
        push = redirectId_i.isCall;
        pop = redirectId_i.isReturn;
        pushAddr = redirectId_i.callPc + 32'd4;
      end else if (found) begin
        push = btbTyp[int'((cur + 32'(4 * fs)) >> 2) % 16] == CALL;
        pop = btbTyp[int'((cur + 32'(4 * fs)) >> 2) % 16] == RETURN;
        pushAddr = cur + 32'(4 * (fs + 1));
      end
    end
    return nxt;
  endfunction

  ////////////////////////////////////////////////////////////
  // failure reporting and compare tasks.
  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkPc(input string name, input logic [`SIZE_PC-1:0] act,
                         input logic [`SIZE_PC-1:0] exp);
    if (act !== exp) reportFailure($sformatf("FAILED %s: got %h expected %h", name, act, exp));
  endtask

  task automatic checkBundle(input bundle_t act, input bundle_t exp);
    if (act !== exp) reportFailure($sformatf("FAILED bundle_o: got %h expected %h", act, exp));
  endtask

  // target only counts on a hit with a known model value.
  task automatic checkSlot(input int s, input slotPred_t act, input slotPred_t exp);
    if (act.btbHit !== exp.btbHit || act.prediction !== exp.prediction ||
        (exp.btbHit && !$isunknown(exp.target) && act.target !== exp.target))
      reportFailure($sformatf("FAILED slotPred_o[%0d]: got %h expected %h", s, act, exp));
  endtask

  ////////////////////////////////////////////////////////////
  // checker, samples between the drive point and the next edge.
  always @(negedge clk) begin : compareCycle
    logic push, pop, miss;
    logic [`SIZE_PC-1:0] pushAddr;
    if (reset) begin
      btbPc.delete();
      rasQ.delete();
      filled.delete();
      for (int i = 0; i < `BPB_ENTRIES; i++) ctr[i] = 2'b01;
      expPc = 0;
    end else begin
      checkPc("pc_o", pc_o, expPc);
      miss = !(filled.exists(int'(pc_o[7:4])) && filled[int'(pc_o[7:4])] == pc_o);
      checkPc("miss_o", 32'(miss_o), 32'(miss));
      checkPc("fs1Ready_o", 32'(fs1Ready_o), 32'(!miss));
      // model pc is bundle-aligned, so it is also the line request.
      checkPc("missAddr_o", missAddr_o, expPc);
      if (!miss) checkBundle(bundle_o, blockFor(pc_o));
      for (int s = 0; s < `FETCH_WIDTH; s++) checkSlot(s, slotPred_o[s], expectSlot(pc_o, s));
      expPc = expectNextPc(pc_o, stall_i || miss, push, pop, pushAddr);
      // commit this cycle's writes into the model.
      if (update_i.en && (update_i.brType != COND || update_i.taken)) begin
        btbPc[int'(update_i.pc[5:2])] = update_i.pc;
        btbTgt[int'(update_i.pc[5:2])] = update_i.target;
        btbTyp[int'(update_i.pc[5:2])] = update_i.brType;
      end
      if (update_i.en && update_i.brType == COND) begin
        if (update_i.taken && ctr[update_i.pc[7:2]] != 2'b11) ctr[update_i.pc[7:2]]++;
        if (!update_i.taken && ctr[update_i.pc[7:2]] != 2'b00) ctr[update_i.pc[7:2]]--;
      end
      if (push && pop) rasQ[$] = pushAddr;
      else if (push) rasQ.push_back(pushAddr);
      else if (pop) void'(rasQ.pop_back());
      if (fill_i.en) filled[int'(fill_i.addr[7:4])] = fill_i.addr;
    end
  end

  ////////////////////////////////////////////////////////////
  // drive helpers.
  // one cycle; pulses clear, a miss asks lower memory for the line.
  task automatic tick();
    @(posedge clk);
    #1;
    recover_i = '0;
    exception_i = '0;
    redirectEx_i = '0;
    redirectId_i = '0;
    update_i = '0;
    fill_i = '0;
    if (autoFill && miss_o) fill_i = '{en: 1'b1, addr: missAddr_o, block: blockFor(missAddr_o)};
  endtask

  task automatic install(input logic [31:0] pc, input logic [31:0] tgt, input ctrlType_e t,
                         input logic taken);
    tick();
    update_i = '{en: 1'b1, pc: pc, target: tgt, brType: t, taken: taken};
  endtask

  task automatic jumpTo(input logic [31:0] addr);
    tick();
    redirectEx_i = '{valid: 1'b1, target: addr};
  endtask

  // decode redirects are dropped on a miss, so wait for a hit.
  task automatic sendId(input idRedirect_t r);
    tick();
    while (miss_o) tick();
    redirectId_i = r;
  endtask

  task automatic waitPc(input logic [31:0] target);
    int n;
    n = 0;
    while (pc_o !== target) begin
      if (n > 60) reportFailure($sformatf("pc never reached %h", target));
      tick();
      n++;
    end
  endtask

  // watchdog.
  initial begin
    #(TotalCycles * 4 * 2);
    reportFailure("watchdog expired before the tests finished");
  end

  initial begin
    clk = 0;
    reset = 1;
    stall_i = 0;
    autoFill = 1;
    rng = 32'd9;
    recover_i = '0;
    exception_i = '0;
    redirectEx_i = '0;
    redirectId_i = '0;
    update_i = '0;
    fill_i = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 0;
    // cold cache, then linear stepping.
    checkPc("missAddr_o", missAddr_o, '0);
    repeat (12) tick();
    // two jumps in one bundle, lower slot wins.
    install(32'h108, 32'h300, JUMP, 1);
    install(32'h104, 32'h200, JUMP, 1);
    jumpTo(32'h100);
    waitPc(32'h200);
    // conditional trained taken, then back to not-taken.
    install(32'h404, 32'h500, COND, 1);
    jumpTo(32'h400);
    waitPc(32'h500);
    install(32'h404, 32'h500, COND, 0);
    install(32'h404, 32'h500, COND, 0);
    jumpTo(32'h400);
    waitPc(32'h410);
    // nested calls and returns from the btb.
    install(32'h60C, 32'h800, CALL, 1);
    install(32'h81C, 32'hA00, CALL, 1);
    install(32'hA00, 32'h0, RETURN, 1);
    install(32'h820, 32'h0, RETURN, 1);
    jumpTo(32'h600);
    waitPc(32'h800);
    waitPc(32'hA00);
    waitPc(32'h820);
    waitPc(32'h610);
    // call and return seen by decode.
    sendId('{valid: 1, isCall: 1, isReturn: 0, callPc: 32'h90C, target: 32'hB00});
    waitPc(32'hB00);
    sendId('{valid: 1, isCall: 0, isReturn: 1, callPc: 0, target: 0});
    waitPc(32'h910);
    // priority among redirects.
    tick();
    recover_i = '{1, 32'h1000};
    exception_i = '{1, 32'h1100};
    redirectEx_i = '{1, 32'h1200};
    redirectId_i = '{valid: 1, isCall: 0, isReturn: 0, callPc: 0, target: 32'h1300};
    tick();
    checkPc("pc_o", pc_o, 32'h1000);
    exception_i = '{1, 32'h1100};
    redirectEx_i = '{1, 32'h1200};
    tick();
    checkPc("pc_o", pc_o, 32'h1100);
    redirectEx_i = '{1, 32'h1200};
    redirectId_i = '{valid: 1, isCall: 0, isReturn: 0, callPc: 0, target: 32'h1300};
    tick();
    checkPc("pc_o", pc_o, 32'h1200);
    stall_i = 1;
    redirectEx_i = '{1, 32'h1400};
    tick();
    checkPc("pc_o", pc_o, 32'h1400);
    redirectId_i = '{valid: 1, isCall: 0, isReturn: 0, callPc: 0, target: 32'h1500};
    tick();
    checkPc("pc_o", pc_o, 32'h1400);
    // line is filled by now, so only the stall holds the pc.
    redirectId_i = '{valid: 1, isCall: 0, isReturn: 0, callPc: 0, target: 32'h1500};
    tick();
    checkPc("pc_o", pc_o, 32'h1400);
    stall_i = 0;
    // random stalls and misses around a pending return.
    sendId('{valid: 1, isCall: 1, isReturn: 0, callPc: 32'h2F0C, target: 32'h2000});
    waitPc(32'h2000);
    for (int i = 0; i < 150; i++) begin
      tick();
      rng = lcg(rng);
      stall_i = rng[20];
      autoFill = rng[22] | rng[23];
      if (rng[27:24] == 4'h0) redirectEx_i = '{1, 32'h2000 + (rng & 32'hFF0)};
      // decode calls and returns while held must leave the ras alone.
      if ((stall_i || miss_o) && rng[27:24] == 4'h1)
        redirectId_i = '{valid: 1, isCall: 1, isReturn: 0, callPc: 32'h3F0C, target: 32'h3000};
      if ((stall_i || miss_o) && rng[27:24] == 4'h2)
        redirectId_i = '{valid: 1, isCall: 0, isReturn: 1, callPc: 0, target: 0};
    end
    tick();
    stall_i = 0;
    autoFill = 1;
    sendId('{valid: 1, isCall: 0, isReturn: 1, callPc: 0, target: 0});
    waitPc(32'h2F10);
    tick();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
fetchPkg.sv
btb.sv
branchPredictor.sv
returnAddrStack.sv
instCache.sv
fetchStage1.sv
tb_fetchStage1.sv

//--- Makefile
SIM = obj_dir/Vtb_fetchStage1
SRCS = fetch_defs.svh fetchPkg.sv btb.sv branchPredictor.sv returnAddrStack.sv \
       instCache.sv fetchStage1.sv tb_fetchStage1.sv

.PHONY: all run check clean

all: $(SIM)

$(SIM): $(SRCS) build.f
	verilator --binary --timing --assert -Wno-fatal -f build.f \
	  --top-module tb_fetchStage1 -o Vtb_fetchStage1

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^TESTS PASSED$$" sim.log

check:
	grep -q "^TESTS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
